/* rvIsaPkg.sv */
package rvIsaPkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int xlen = 32;                  // Register and data width
    localparam int ilen = 32;                  // Base instruction length

    typedef logic [ilen-1:0] instr_t;

    ////////////////////////////////////////
    // Major opcodes, instr[6:0]
    ////////////////////////////////////////
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opJal    = 7'b1101111;

    // funct7 values
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;   // SUB and SRA variants

    // funct3 for OP and OP-IMM
    localparam logic [2:0] f3Add  = 3'b000;
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Sr   = 3'b101;   // SRL or SRA by funct7
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

endpackage

/* rvCtrlPkg.sv */
package rvCtrlPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSrl,
        aluSra,
        aluXor,
        aluOr,
        aluAnd,
        aluSlt,
        aluSltu,
        aluPassB                               // Operand B straight through
    } aluOp_t;

    // Same coding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {memByte, memHalf, memWord} memWidth_t;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immKind_t;

    typedef enum logic [1:0] {wbAlu, wbMem, wbPc4} wbSel_t;

    typedef enum logic {aRs1, aPc} aSel_t;

    ////////////////////////////////////////
    // Decoded control word
    ////////////////////////////////////////
    typedef struct packed {
        logic      regWrite;
        aluOp_t    aluOp;
        logic      memRead;
        logic      memWrite;
        memWidth_t memWidth;
        logic      memUnsigned;
        logic      aluSrcImm;                  // Operand B from immediate
        aSel_t     aSel;
        wbSel_t    wbSel;
        logic      branch;
        logic      jump;
        logic      jumpReg;                    // JALR target base is rs1
        logic [2:0] brCond;                    // Branch funct3
        immKind_t  immKind;
        logic      illegal;
    } ctrl_t;

    ////////////////////////////////////////
    // Execute result, registered at the top
    ////////////////////////////////////////
    typedef struct packed {
        logic [rvIsaPkg::xlen-1:0] aluResult;
        logic [rvIsaPkg::xlen-1:0] storeData;
        logic [rvIsaPkg::xlen-1:0] takenTarget;
        logic      redirect;
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
        memWidth_t memWidth;
        logic      memUnsigned;
        wbSel_t    wbSel;
        logic      illegal;
    } exResult_t;

endpackage

/* controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder (
    input  rvIsaPkg::instr_t instr,
    output rvCtrlPkg::ctrl_t ctrl
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Shared ALU op lookup for OP and OP-IMM
    function automatic aluOp_t aluFromF3(input logic [2:0] f3, input logic alt);
        aluOp_t op;
        case (f3)
            f3Add:   op = alt ? aluSub : aluAdd;
            f3Sll:   op = aluSll;
            f3Slt:   op = aluSlt;
            f3Sltu:  op = aluSltu;
            f3Xor:   op = aluXor;
            f3Sr:    op = alt ? aluSra : aluSrl;
            f3Or:    op = aluOr;
            f3And:   op = aluAnd;
            default: op = aluAdd;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb
    begin
        ctrl          = '0;                    // Everything defined, never X
        ctrl.aluOp    = aluAdd;
        ctrl.memWidth = memWord;
        ctrl.aSel     = aRs1;
        ctrl.wbSel    = wbAlu;
        ctrl.immKind  = immI;
        ctrl.brCond   = funct3;
        case (opcode)
            opOp:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFromF3(funct3, funct7 == f7Alt);
                if (funct7 != f7Base && !(funct7 == f7Alt && (funct3 == f3Add || funct3 == f3Sr)))
                    ctrl.illegal = 1'b1;       // Only SUB and SRA take f7Alt
            end
            opOpImm:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluFromF3(funct3, funct3 == f3Sr && funct7 == f7Alt);
                if (funct3 == f3Sll && funct7 != f7Base)
                    ctrl.illegal = 1'b1;
                if (funct3 == f3Sr && funct7 != f7Base && funct7 != f7Alt)
                    ctrl.illegal = 1'b1;
            end
            opLoad:
            begin
                ctrl.regWrite    = 1'b1;
                ctrl.memRead     = 1'b1;
                ctrl.aluSrcImm   = 1'b1;
                ctrl.wbSel       = wbMem;
                ctrl.memWidth    = memWidth_t'(funct3[1:0]);
                ctrl.memUnsigned = funct3[2];
                // LB LH LW LBU LHU only
                ctrl.illegal     = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
            end
            opStore:
            begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immKind   = immS;
                ctrl.memWidth  = memWidth_t'(funct3[1:0]);
                ctrl.illegal   = funct3[2] || (funct3[1:0] == 2'b11);
            end
            opBranch:
            begin
                ctrl.branch  = 1'b1;
                ctrl.aluOp   = aluSub;
                ctrl.immKind = immB;
                ctrl.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            opJal:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.immKind  = immJ;
            end
            opJalr:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.jumpReg  = 1'b1;
                ctrl.illegal  = (funct3 != 3'b000);
            end
            opLui:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluPassB;
                ctrl.immKind   = immU;
            end
            opAuipc:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aSel      = aPc;          // pc + upper immediate
                ctrl.immKind   = immU;
            end
            default: ctrl.illegal = 1'b1;      // CSR, FENCE, SYSTEM and unknown
        endcase

        // Illegal encodings have no side effects
        if (ctrl.illegal)
        begin
            ctrl.regWrite = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.branch   = 1'b0;
            ctrl.jump     = 1'b0;
            ctrl.jumpReg  = 1'b0;
        end
    end

endmodule

/* immGenerator.sv */
`timescale 1ns/1ps

module immGenerator (
    input  rvIsaPkg::instr_t              instr,
    input  rvCtrlPkg::immKind_t           immKind,
    output logic [rvIsaPkg::xlen-1:0]     imm
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic sign;

    assign sign = instr[31];                   // Sign bit is always instr[31]

    always_comb
    begin
        case (immKind)
            immI:
                imm = {{(xlen-12){sign}}, instr[31:20]};
            immS:
                imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            immB:
            begin
                // Halfword aligned branch offset
                imm = {{(xlen-13){sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            immU:
                imm = {instr[31:12], 12'b0};
            immJ:
            begin
                imm = {{(xlen-21){sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default:
                imm = '0;
        endcase
    end

endmodule

/* executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
    input  rvCtrlPkg::ctrl_t            ctrl,
    input  logic [rvIsaPkg::xlen-1:0]   imm,
    input  logic [rvIsaPkg::xlen-1:0]   pc,
    input  logic [rvIsaPkg::xlen-1:0]   rs1Data,
    input  logic [rvIsaPkg::xlen-1:0]   rs2Data,
    output rvCtrlPkg::exResult_t        next
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] jalrSum;
    logic [4:0]      shamt;
    logic            brTaken;

    assign opA   = (ctrl.aSel == aPc) ? pc : rs1Data;
    assign opB   = ctrl.aluSrcImm ? imm : rs2Data;
    assign shamt = opB[4:0];                   // Low 5 bits only

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb
    begin
        case (ctrl.aluOp)
            aluAdd:   aluOut = opA + opB;
            aluSub:   aluOut = opA - opB;
            aluSll:   aluOut = opA << shamt;
            aluSrl:   aluOut = opA >> shamt;
            aluSra:   aluOut = $unsigned($signed(opA) >>> shamt);
            aluXor:   aluOut = opA ^ opB;
            aluOr:    aluOut = opA | opB;
            aluAnd:   aluOut = opA & opB;
            aluSlt:   aluOut = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu:  aluOut = {{(xlen-1){1'b0}}, opA < opB};
            aluPassB: aluOut = opB;
            default:  aluOut = '0;
        endcase
    end

    ////////////////////////////////////////
    // Branch compare, always on rs1 and rs2
    ////////////////////////////////////////
    always_comb
    begin
        case (ctrl.brCond)
            f3Beq:   brTaken = (rs1Data == rs2Data);
            f3Bne:   brTaken = (rs1Data != rs2Data);
            f3Blt:   brTaken = ($signed(rs1Data) < $signed(rs2Data));
            f3Bge:   brTaken = ($signed(rs1Data) >= $signed(rs2Data));
            f3Bltu:  brTaken = (rs1Data < rs2Data);
            f3Bgeu:  brTaken = (rs1Data >= rs2Data);
            default: brTaken = 1'b0;
        endcase
    end

    assign jalrSum = rs1Data + imm;

    always_comb
    begin
        next.aluResult   = ctrl.jump ? pc + xlen'(4) : aluOut;   // Link address
        next.storeData   = rs2Data;
        next.takenTarget = ctrl.jumpReg ? {jalrSum[xlen-1:1], 1'b0} : pc + imm;
        next.redirect    = ctrl.jump || (ctrl.branch && brTaken);
        next.regWrite    = ctrl.regWrite;
        next.memRead     = ctrl.memRead;
        next.memWrite    = ctrl.memWrite;
        next.memWidth    = ctrl.memWidth;
        next.memUnsigned = ctrl.memUnsigned;
        next.wbSel       = ctrl.wbSel;
        next.illegal     = ctrl.illegal;
    end

endmodule

/* decodeExecute.sv */
`timescale 1ns/1ps

module decodeExecute (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        instrValid,
    input  rvIsaPkg::instr_t            instr,
    input  logic [rvIsaPkg::xlen-1:0]   pc,
    input  logic [rvIsaPkg::xlen-1:0]   rs1Data,
    input  logic [rvIsaPkg::xlen-1:0]   rs2Data,
    output rvCtrlPkg::exResult_t        res,
    output logic                        resValid
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    exResult_t       next;

    controlDecoder uDecoder (.instr(instr), .ctrl(ctrl));

    immGenerator uImmGen (.instr(instr), .immKind(ctrl.immKind), .imm(imm));

    executeUnit uExecute (
        .ctrl    (ctrl),
        .imm     (imm),
        .pc      (pc),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .next    (next)
    );

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            resValid        <= 1'b0;
            res.regWrite    <= 1'b0;           // Control bits only
            res.memRead     <= 1'b0;
            res.memWrite    <= 1'b0;
            res.memWidth    <= memByte;
            res.memUnsigned <= 1'b0;
            res.wbSel       <= wbAlu;
            res.redirect    <= 1'b0;
            res.illegal     <= 1'b0;
        end
        else
        begin
            resValid <= instrValid;
            if (instrValid)
                res <= next;                   // Hold on idle slots
        end
    end

    // Nothing valid comes out of reset
    assert property (@(posedge clk) !rstN |=> !resValid);

    // Illegal decode reaches the register with its side effects removed
    assert property (@(posedge clk) disable iff (!rstN)
        instrValid && ctrl.illegal |=>
            resValid && res.illegal && !res.regWrite && !res.memWrite);

    assert property (@(posedge clk) disable iff (!rstN)
        res.illegal |-> !(res.regWrite || res.memWrite || res.redirect));

endmodule

/* tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;                      // 8 ns period

endmodule

/* tbDecodeExecute.sv */
`timescale 1ns/1ps

module tbDecodeExecute;
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    typedef struct {
        string           name;
        logic            valid;
        instr_t          instr;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        exResult_t       exp;
        exResult_t       care;                 // Set bits are compared
    } row_t;

    logic            clk;
    logic            rstN;
    logic            instrValid;
    instr_t          instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    exResult_t       res;
    logic            resValid;

    row_t rows[$];
    int   seed = 32'hb2cd;
    int   cycles = 0;
    int   cycleLimit = 1000;

    tbClockGen uClock (.clk(clk));

    decodeExecute dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .res        (res),
        .resValid   (resValid)
    );

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic instr_t encR(input logic [6:0] f7, input logic [2:0] f3,
                                    input logic [6:0] op);
        return {f7, 5'd3, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic instr_t encI(input logic [11:0] imm, input logic [2:0] f3,
                                    input logic [6:0] op);
        return {imm, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic instr_t encS(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd3, 5'd2, f3, imm[4:0], opStore};
    endfunction

    function automatic instr_t encB(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd3, 5'd2, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic instr_t encU(input logic [19:0] imm, input logic [6:0] op);
        return {imm, 5'd1, op};
    endfunction

    function automatic instr_t encJ(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, opJal};
    endfunction

    ////////////////////////////////////////
    // Reference model from the RV32I spec
    ////////////////////////////////////////
    task automatic refModel(input instr_t i, input logic [xlen-1:0] pcIn,
                            input logic [xlen-1:0] rs1, input logic [xlen-1:0] rs2,
                            output exResult_t e, output exResult_t m);
        logic [6:0]        op;
        logic [2:0]        f3;
        logic [6:0]        f7;
        logic [xlen-1:0]   iImm;
        logic [xlen-1:0]   sImm;
        logic [xlen-1:0]   bImm;
        logic [xlen-1:0]   uImm;
        logic [xlen-1:0]   jImm;
        logic [xlen-1:0]   b;
        logic signed [xlen-1:0] sra;
        logic              legal;
        op   = i[6:0];
        f3   = i[14:12];
        f7   = i[31:25];
        iImm = {{20{i[31]}}, i[31:20]};
        sImm = {{20{i[31]}}, i[31:25], i[11:7]};
        bImm = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        uImm = {i[31:12], 12'b0};
        jImm = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        legal = 1'b1;
        e = '0;
        m = '0;
        m.aluResult = '1;
        m.regWrite  = 1'b1;
        m.memRead   = 1'b1;
        m.memWrite  = 1'b1;
        m.redirect  = 1'b1;
        m.illegal   = 1'b1;
        case (op)
            opOp, opOpImm:
            begin
                b   = (op == opOp) ? rs2 : iImm;
                sra = $signed(rs1) >>> b[4:0];
                if (op == opOp)
                    legal = (f7 == f7Base) || (f7 == f7Alt && (f3 == f3Add || f3 == f3Sr));
                else if (f3 == f3Sll)
                    legal = (f7 == f7Base);
                else if (f3 == f3Sr)
                    legal = (f7 == f7Base) || (f7 == f7Alt);
                case (f3)
                    f3Add:   e.aluResult = (op == opOp && f7 == f7Alt) ? rs1 - b : rs1 + b;
                    f3Sll:   e.aluResult = rs1 << b[4:0];
                    f3Slt:   e.aluResult = {31'b0, $signed(rs1) < $signed(b)};
                    f3Sltu:  e.aluResult = {31'b0, rs1 < b};
                    f3Xor:   e.aluResult = rs1 ^ b;
                    f3Sr:    e.aluResult = (f7 == f7Alt) ? sra : rs1 >> b[4:0];
                    f3Or:    e.aluResult = rs1 | b;
                    default: e.aluResult = rs1 & b;
                endcase
                e.regWrite = 1'b1;
            end
            opLoad:
            begin
                legal         = (f3 != 3'b011) && (f3[2:1] != 2'b11);
                e.aluResult   = rs1 + iImm;
                e.regWrite    = 1'b1;
                e.memRead     = 1'b1;
                e.wbSel       = wbMem;
                e.memWidth    = memWidth_t'(f3[1:0]);
                e.memUnsigned = f3[2];
                m.memWidth    = memWidth_t'(2'b11);
                m.memUnsigned = 1'b1;
            end
            opStore:
            begin
                legal       = !f3[2] && (f3[1:0] != 2'b11);
                e.aluResult = rs1 + sImm;
                e.memWrite  = 1'b1;
                e.storeData = rs2;
                e.memWidth  = memWidth_t'(f3[1:0]);
                m.storeData = '1;
                m.memWidth  = memWidth_t'(2'b11);
            end
            opBranch:
            begin
                legal = (f3[2:1] != 2'b01);
                case (f3)
                    f3Beq:   e.redirect = (rs1 == rs2);
                    f3Bne:   e.redirect = (rs1 != rs2);
                    f3Blt:   e.redirect = ($signed(rs1) < $signed(rs2));
                    f3Bge:   e.redirect = ($signed(rs1) >= $signed(rs2));
                    f3Bltu:  e.redirect = (rs1 < rs2);
                    default: e.redirect = (rs1 >= rs2);
                endcase
                e.takenTarget = pcIn + bImm;
                m.takenTarget = '1;
                m.aluResult   = '0;
            end
            opJal, opJalr:
            begin
                legal         = (op == opJal) || (f3 == 3'b000);
                e.regWrite    = 1'b1;
                e.redirect    = 1'b1;
                e.aluResult   = pcIn + 32'd4;  // Link address
                e.takenTarget = (op == opJal) ? pcIn + jImm : (rs1 + iImm) & ~32'h1;
                m.takenTarget = '1;
            end
            opLui, opAuipc:
            begin
                e.aluResult = (op == opLui) ? uImm : pcIn + uImm;
                e.regWrite  = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (e.regWrite)
            m.wbSel = wbSel_t'(2'b11);
        if (!legal)
        begin
            e = '0;
            e.illegal  = 1'b1;
            m = '0;
            m.regWrite = 1'b1;
            m.memRead  = 1'b1;
            m.memWrite = 1'b1;
            m.redirect = 1'b1;
            m.illegal  = 1'b1;
        end
    endtask

    task automatic addRow(input string name, input instr_t i, input logic [xlen-1:0] pcIn,
                          input logic [xlen-1:0] rs1, input logic [xlen-1:0] rs2);
        row_t r;
        r.name  = name;
        r.valid = 1'b1;
        r.instr = i;
        r.pc    = pcIn;
        r.rs1   = rs1;
        r.rs2   = rs2;
        refModel(i, pcIn, rs1, rs2, r.exp, r.care);
        rows.push_back(r);
    endtask

    // Idle slot, the previous result must hold
    task automatic addIdle(input string name);
        row_t r;
        r       = rows[rows.size()-1];
        r.name  = name;
        r.valid = 1'b0;
        r.instr = '0;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        addRow("ADD", encR(f7Base, f3Add, opOp), 32'h2000, $random(seed), $random(seed));
        addRow("SUB", encR(f7Alt, f3Add, opOp), 32'h2004, $random(seed), $random(seed));
        addRow("SLL", encR(f7Base, f3Sll, opOp), 32'h2008, $random(seed), $random(seed));
        addRow("SLT", encR(f7Base, f3Slt, opOp), 32'h200c, $random(seed), $random(seed));
        addRow("SLT neg", encR(f7Base, f3Slt, opOp), 32'h2010, 32'hffff_fff0, 32'h5);
        addRow("SLTU", encR(f7Base, f3Sltu, opOp), 32'h2014, 32'h5, 32'hffff_fff0);
        addRow("MUL illegal", encR(7'b0000001, f3Add, opOp), 32'h2018, 32'h3, 32'h4);
        addRow("XOR", encR(f7Base, f3Xor, opOp), 32'h201c, $random(seed), $random(seed));
        addRow("SRL", encR(f7Base, f3Sr, opOp), 32'h2020, $random(seed), $random(seed));
        addRow("SRA", encR(f7Alt, f3Sr, opOp), 32'h2024, 32'h8000_1234, $random(seed));
        addRow("OR", encR(f7Base, f3Or, opOp), 32'h2028, $random(seed), $random(seed));
        addRow("AND", encR(f7Base, f3And, opOp), 32'h202c, $random(seed), $random(seed));
        addRow("XOR alt illegal", encR(f7Alt, f3Xor, opOp), 32'h2030, 32'h1, 32'h2);
        addRow("ADDI", encI(12'h805, f3Add, opOpImm), 32'h2034, $random(seed), 32'h0);
        addRow("SLTI", encI(12'hfff, f3Slt, opOpImm), 32'h2038, $random(seed), 32'h0);
        addRow("SLTIU", encI(12'hfff, f3Sltu, opOpImm), 32'h203c, $random(seed), 32'h0);
        addRow("XORI", encI(12'h4a5, f3Xor, opOpImm), 32'h2040, $random(seed), 32'h0);
        addRow("ORI", encI(12'h0f0, f3Or, opOpImm), 32'h2044, $random(seed), 32'h0);
        addRow("ANDI", encI(12'h7ff, f3And, opOpImm), 32'h2048, $random(seed), 32'h0);
        addRow("SLLI", encI({f7Base, 5'd7}, f3Sll, opOpImm), 32'h204c, $random(seed), 32'h0);
        addRow("SRLI", encI({f7Base, 5'd13}, f3Sr, opOpImm), 32'h2050, $random(seed), 32'h0);
        addRow("SRAI", encI({f7Alt, 5'd13}, f3Sr, opOpImm), 32'h2054, 32'h8000_1234, 32'h0);
        addRow("SLLI illegal", encI({f7Alt, 5'd3}, f3Sll, opOpImm), 32'h2058, 32'h1, 32'h0);
        addIdle("idle after ALU");
        addRow("LB", encI(12'hffc, 3'b000, opLoad), 32'h205c, 32'h1000_0000, 32'h0);
        addRow("LH", encI(12'h010, 3'b001, opLoad), 32'h2060, $random(seed), 32'h0);
        addRow("LW", encI(12'h804, 3'b010, opLoad), 32'h2064, $random(seed), 32'h0);
        addRow("LBU", encI(12'h001, 3'b100, opLoad), 32'h2068, $random(seed), 32'h0);
        addRow("LHU", encI(12'h7fe, 3'b101, opLoad), 32'h206c, $random(seed), 32'h0);
        addRow("SB", encS(12'h7f8, 3'b000), 32'h2070, $random(seed), $random(seed));
        addRow("SH", encS(12'h804, 3'b001), 32'h2074, $random(seed), $random(seed));
        addRow("SW", encS(12'h020, 3'b010), 32'h2078, $random(seed), $random(seed));
        addRow("ECALL illegal", 32'h0000_0073, 32'h207c, 32'h0, 32'h0);
        addRow("BEQ taken", encB(13'h0010, f3Beq), 32'h2080, 32'h5, 32'h5);
        addRow("BEQ", encB(13'h0010, f3Beq), 32'h2084, $random(seed), $random(seed));
        addRow("BNE", encB(13'h0ffc, f3Bne), 32'h2088, $random(seed), $random(seed));
        addRow("BLT", encB(13'h1ff0, f3Blt), 32'h208c, 32'hffff_ffff, 32'h1);
        addRow("BGE", encB(13'h0040, f3Bge), 32'h2090, 32'hffff_ffff, 32'h1);
        addRow("BLTU", encB(13'h0040, f3Bltu), 32'h2094, 32'hffff_ffff, 32'h1);
        addRow("BGEU", encB(13'h1800, f3Bgeu), 32'h2098, 32'hffff_ffff, 32'h1);
        addIdle("idle after branch");
        addRow("JAL", encJ(21'h000804), 32'h3000, $random(seed), $random(seed));
        addRow("JAL back", encJ(21'h1ffff8), 32'h3004, $random(seed), $random(seed));
        addRow("JALR", encI(12'h005, 3'b000, opJalr), 32'h3008, 32'h1000, 32'h0);
        addRow("JALR neg", encI(12'hff1, 3'b000, opJalr), 32'h300c, $random(seed), 32'h0);
        addRow("LUI", encU(20'hdead0, opLui), 32'h4000, $random(seed), $random(seed));
        addRow("AUIPC", encU(20'h00012, opAuipc), 32'h4004, $random(seed), $random(seed));
    endtask

    ////////////////////////////////////////
    // Compare and abort helpers
    ////////////////////////////////////////
    task automatic abortRun(input string why);
        $display("Test FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic checkResult(input string name, input exResult_t exp,
                               input exResult_t care, input exResult_t act);
        logic [$bits(exResult_t)-1:0] e;
        logic [$bits(exResult_t)-1:0] a;
        e = exp & care;
        a = act & care;
        if (a !== e)
        begin
            $display("ERR %s: expected %h, actual %h", name, e, a);
            abortRun("execute result mismatch");
        end
    endtask

    task automatic checkValid(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %s resValid: expected %b, actual %b", name, exp, act);
            abortRun("resValid mismatch");
        end
    endtask

    task automatic checkCtrl(input string name, input string field, input logic exp,
                             input logic act);
        if (act !== exp)
        begin
            $display("ERR %s %s: expected %b, actual %b", name, field, exp, act);
            abortRun("control bit mismatch");
        end
    endtask

    task automatic applyRow(input row_t r);
        instrValid = r.valid;
        instr      = r.instr;
        pc         = r.pc;
        rs1Data    = r.rs1;
        rs2Data    = r.rs2;
    endtask

    // Guard against a stalled run
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycleLimit)
            abortRun("timeout, the run went past its cycle limit");
    end

    initial
    begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        rs1Data    = '0;
        rs2Data    = '0;
        buildTable();
        cycleLimit = 10 + 2 * rows.size() + 20;

        repeat (10) @(posedge clk);
        #1 rstN = 1'b1;
        checkValid("reset", 1'b0, resValid);
        checkCtrl("reset", "regWrite", 1'b0, res.regWrite);
        checkCtrl("reset", "memWrite", 1'b0, res.memWrite);
        checkCtrl("reset", "redirect", 1'b0, res.redirect);
        @(posedge clk);
        #1 checkValid("idle after reset", 1'b0, resValid);

        // One row per cycle, result checked on the next edge
        for (int k = 0; k < rows.size(); k++)
        begin
            applyRow(rows[k]);
            @(posedge clk);
            #1;
            checkValid(rows[k].name, rows[k].valid, resValid);
            checkResult(rows[k].name, rows[k].exp, rows[k].care, res);
        end

        instrValid = 1'b0;
        @(posedge clk);
        #1 checkValid("final idle", 1'b0, resValid);
        $display("Test OK");
        $finish;
    end

endmodule

/* files.f */
rvIsaPkg.sv
rvCtrlPkg.sv
controlDecoder.sv
immGenerator.sv
executeUnit.sv
decodeExecute.sv
tbClockGen.sv
tbDecodeExecute.sv

/* Makefile */
# Verilator build for the decode and execute slice

VERILATOR ?= verilator
TOP       ?= tbDecodeExecute
RTL_TOP   ?= decodeExecute
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint lint-rtl sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

lint-rtl:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) \
		rvIsaPkg.sv rvCtrlPkg.sv controlDecoder.sv immGenerator.sv \
		executeUnit.sv decodeExecute.sv

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
